/* sine_table.svh */
// quarter-wave sine table, sin(k * pi / 128) for k = 0..64 in Q16
// the angle-code lookup mirrors and negates these for the other quadrants
localparam logic [16:0] SINE_Q16 [65] = '{
	17'd0,     17'd1608,
	17'd3216,  17'd4821,
	17'd6424,  17'd8022,
	17'd9616,  17'd11204,
	17'd12785, 17'd14359,
	17'd15924, 17'd17479,
	17'd19024, 17'd20557,
	17'd22078, 17'd23586,
	17'd25080, 17'd26558, // k = 16, 22.5 degrees
	17'd28020, 17'd29466,
	17'd30893, 17'd32303,
	17'd33692, 17'd35062,
	17'd36410, 17'd37736,
	17'd39040, 17'd40320,
	17'd41576, 17'd42806,
	17'd44011, 17'd45190,
	17'd46341, 17'd47464, // 45 degrees
	17'd48559, 17'd49624,
	17'd50660, 17'd51665,
	17'd52639, 17'd53581,
	17'd54491, 17'd55368,
	17'd56212, 17'd57022,
	17'd57798, 17'd58538,
	17'd59244, 17'd59914,
	17'd60547, 17'd61145,
	17'd61705, 17'd62228,
	17'd62714, 17'd63162,
	17'd63572, 17'd63944,
	17'd64277, 17'd64571,
	17'd64827, 17'd65043,
	17'd65220, 17'd65358,
	17'd65457, 17'd65516,
	17'd65536 // exactly 1.0
};

/* ik_fixed_pkg.sv */
// fixed-point arithmetic for the kinematics datapath
// 27-bit signed words with 16 fraction bits, angle codes of 256 steps per turn,
// matrix index types and the chain FSM encoding
package ik_fixed_pkg;

	localparam int WORD_W = 27;
	localparam int FRAC_BITS = 16;

	typedef logic signed [WORD_W-1:0] fix_t;
	typedef logic signed [2*WORD_W-1:0] fix_wide_t; // full product width
	typedef logic [7:0] angle_t; // 64 is a quarter turn
	typedef logic [1:0] row_t;
	typedef logic [1:0] col_t;

	typedef enum logic [1:0] {IDLE, BUILD, MULT, DONE} chain_state_t;

	localparam fix_t FIX_ONE = fix_t'(1) <<< FRAC_BITS;

`include "sine_table.svh"

	// quadrant symmetry on the quarter-wave table
	function automatic fix_t fix_sin(angle_t ang);
		logic [6:0] idx;
		fix_t mag;
		idx = ang[6] ? 7'd64 - {1'b0, ang[5:0]} : {1'b0, ang[5:0]};
		mag = fix_t'({10'b0, SINE_Q16[idx]});
		return ang[7] ? -mag : mag; // lower half of the turn is negative
	endfunction

	function automatic fix_t fix_cos(angle_t ang);
		return fix_sin(angle_t'(ang + 8'd64));
	endfunction

	// product rescaled by an arithmetic shift, so it rounds toward minus infinity
	function automatic fix_wide_t fix_mul_full(fix_t a, fix_t b);
		fix_wide_t prod;
		prod = fix_wide_t'(a) * fix_wide_t'(b);
		return prod >>> FRAC_BITS;
	endfunction

	function automatic fix_t fix_mul(fix_t a, fix_t b);
		return fix_t'(fix_mul_full(a, b)); // wraps to the word width
	endfunction

endpackage

/* ik_regmap_pkg.sv */
// host address map of the parameter register file
// bytes are written most significant first, 4 per 27-bit word
package ik_regmap_pkg;

	typedef logic [6:0] addr_t;
	typedef logic [7:0] byte_t;

	localparam int TARGET_BASE = 0; // x, y, z words
	localparam int JOINT_TYPE_ADDR = 12; // accepted, no effect on the forward matrix
	localparam int DH_BASE = 13;
	localparam int BYTES_PER_WORD = 4;
	localparam int DH_FIELDS = 4;

	// field order inside one joint's block
	localparam int THETA = 0;
	localparam int L_OFFSET = 1;
	localparam int L_DISTANCE = 2;
	localparam int ALPHA = 3;

	// fixed above the largest DH block
	localparam addr_t START_ADDR = 7'd109;

endpackage

/* ik_ifs.sv */
// buses between the register file, the DH chain and the readout
// dh_param_if carries the host parameters and the start/busy pair,
// pose_if carries the cumulative frames and the done pulse
`timescale 1ns/100ps

interface dh_param_if #(parameter int MAX_JOINT = 6);

	ik_fixed_pkg::fix_t dh [MAX_JOINT][ik_regmap_pkg::DH_FIELDS]; // theta, d, a, alpha
	ik_fixed_pkg::fix_t target [3];
	logic start; // one-cycle strobe
	logic busy;

	modport regs (output dh, output target, output start, input busy);
	modport chain (input dh, input start, output busy);
	modport readout (input target);

endinterface

interface pose_if #(parameter int MAX_JOINT = 6);

	// rows 0..2 only, row 3 is always 0 0 0 1
	ik_fixed_pkg::fix_t frames [MAX_JOINT][3][4];
	logic done;
	ik_fixed_pkg::fix_t end_x; // origin of the last frame
	ik_fixed_pkg::fix_t end_y;
	ik_fixed_pkg::fix_t end_z;

	modport chain (
		output frames,
		output done,
		output end_x,
		output end_y,
		output end_z
	);

	modport readout (
		input frames,
		input done,
		input end_x,
		input end_y,
		input end_z
	);

endinterface

/* ik_param_regs.sv */
// byte-wide host register file for the target and the DH parameters
// address decode is computed from the map layout, a write to START_ADDR
// gives a one-cycle start strobe on the following cycle
`timescale 1ns/100ps

module ik_param_regs #(
	parameter int MAX_JOINT = 6
) (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input logic write,
	input ik_regmap_pkg::addr_t address,
	input ik_regmap_pkg::byte_t writedata,
	dh_param_if.regs regs
);

	localparam int JOINT_SPAN = ik_regmap_pkg::DH_FIELDS * ik_regmap_pkg::BYTES_PER_WORD;
	localparam int DH_END = ik_regmap_pkg::DH_BASE + MAX_JOINT * JOINT_SPAN;

	logic wr_en;
	logic hit_target;
	logic hit_dh;
	logic [6:0] tgt_off;
	logic [6:0] dh_off;
	logic [1:0] tgt_word;
	logic [2:0] dh_joint;
	logic [1:0] dh_field;
	logic [1:0] lane; // byte position, 0 is the top byte

	// drop everything while a run is in progress
	assign wr_en = chipselect && write && !regs.busy;

	assign hit_target = int'(address) >= ik_regmap_pkg::TARGET_BASE &&
		int'(address) < ik_regmap_pkg::JOINT_TYPE_ADDR;
	assign hit_dh = int'(address) >= ik_regmap_pkg::DH_BASE && int'(address) < DH_END;

	assign tgt_off = address - 7'(ik_regmap_pkg::TARGET_BASE);
	assign dh_off = address - 7'(ik_regmap_pkg::DH_BASE);
	assign tgt_word = 2'(tgt_off / ik_regmap_pkg::BYTES_PER_WORD);
	assign dh_joint = 3'(dh_off / JOINT_SPAN);
	assign dh_field = 2'((dh_off / ik_regmap_pkg::BYTES_PER_WORD) % ik_regmap_pkg::DH_FIELDS);
	assign lane = hit_dh ? 2'(dh_off % ik_regmap_pkg::BYTES_PER_WORD) :
		2'(tgt_off % ik_regmap_pkg::BYTES_PER_WORD);

	// merge one host byte into a word
	function automatic ik_fixed_pkg::fix_t put_byte(ik_fixed_pkg::fix_t word, logic [1:0] ln,
		ik_regmap_pkg::byte_t b);
		ik_fixed_pkg::fix_t w;
		w = word;
		case (ln)
			2'd0: w[26:24] = b[2:0]; // top byte holds only 3 bits
			2'd1: w[23:16] = b;
			2'd2: w[15:8] = b;
			default: w[7:0] = b;
		endcase
		return w;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			regs.dh <= '{default: '0};
			regs.target <= '{default: '0};
		end else if (wr_en) begin
			if (hit_target) begin
				regs.target[tgt_word] <= put_byte(regs.target[tgt_word], lane, writedata);
			end else if (hit_dh) begin
				regs.dh[dh_joint][dh_field] <=
					put_byte(regs.dh[dh_joint][dh_field], lane, writedata);
			end
		end
	end

	// a second start write right behind the first is not repeated,
	// busy is not yet up to block it
	always_ff @(posedge clk) begin
		if (reset) begin
			regs.start <= 1'b0;
		end else begin
			regs.start <= wr_en && address == ik_regmap_pkg::START_ADDR && !regs.start;
		end
	end

endmodule

/* dh_chain.sv */
// forward kinematics chain, one joint at a time
// a BUILD cycle forms the joint's DH matrix, then 12 MULT cycles compute
// one element each of T(j) = T(j-1) * A(j), with T(-1) the identity
`timescale 1ns/100ps

module dh_chain #(
	parameter int MAX_JOINT = 6
) (
	input logic clk,
	input logic reset,
	dh_param_if.chain prm,
	pose_if.chain pose
);

	ik_fixed_pkg::chain_state_t state;
	logic [2:0] joint;
	ik_fixed_pkg::row_t row;
	ik_fixed_pkg::col_t col;

	ik_fixed_pkg::fix_t dh_mat [3][4]; // current joint's matrix, rows 0..2
	ik_fixed_pkg::fix_t prev [3][4]; // copy of the previous cumulative frame
	ik_fixed_pkg::fix_t mat_col [4];
	ik_fixed_pkg::fix_t elem_sum;

	ik_fixed_pkg::angle_t theta_ang;
	ik_fixed_pkg::angle_t alpha_ang;
	ik_fixed_pkg::fix_t st;
	ik_fixed_pkg::fix_t ct;
	ik_fixed_pkg::fix_t sa;
	ik_fixed_pkg::fix_t ca;
	ik_fixed_pkg::fix_t a_len;
	ik_fixed_pkg::fix_t d_off;

	// angles are taken from the low byte of the word
	assign theta_ang = prm.dh[joint][ik_regmap_pkg::THETA][7:0];
	assign alpha_ang = prm.dh[joint][ik_regmap_pkg::ALPHA][7:0];
	assign a_len = prm.dh[joint][ik_regmap_pkg::L_DISTANCE];
	assign d_off = prm.dh[joint][ik_regmap_pkg::L_OFFSET];

	assign st = ik_fixed_pkg::fix_sin(theta_ang);
	assign ct = ik_fixed_pkg::fix_cos(theta_ang);
	assign sa = ik_fixed_pkg::fix_sin(alpha_ang);
	assign ca = ik_fixed_pkg::fix_cos(alpha_ang);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ik_fixed_pkg::IDLE;
			joint <= '0;
			row <= '0;
			col <= '0;
		end else begin
			case (state)
				ik_fixed_pkg::IDLE: begin
					if (prm.start) begin
						state <= ik_fixed_pkg::BUILD;
						joint <= '0;
					end
				end
				ik_fixed_pkg::BUILD: begin
					state <= ik_fixed_pkg::MULT;
					row <= '0;
					col <= '0;
				end
				ik_fixed_pkg::MULT: begin
					if (col == 2'd3) begin
						col <= '0;
						if (row == 2'd2) begin // frame complete
							if (joint == 3'(MAX_JOINT - 1)) begin
								state <= ik_fixed_pkg::DONE;
							end else begin
								joint <= joint + 3'd1;
								state <= ik_fixed_pkg::BUILD;
							end
						end else begin
							row <= row + 2'd1;
						end
					end else begin
						col <= col + 2'd1;
					end
				end
				default: state <= ik_fixed_pkg::IDLE; // done lasts one cycle
			endcase
		end
	end

	// DH matrix and the previous frame, latched once per joint
	always_ff @(posedge clk) begin
		if (state == ik_fixed_pkg::BUILD) begin
			dh_mat[0][0] <= ct;
			dh_mat[0][1] <= -ik_fixed_pkg::fix_mul(st, ca);
			dh_mat[0][2] <= ik_fixed_pkg::fix_mul(st, sa);
			dh_mat[0][3] <= ik_fixed_pkg::fix_mul(a_len, ct);
			dh_mat[1][0] <= st;
			dh_mat[1][1] <= ik_fixed_pkg::fix_mul(ct, ca);
			dh_mat[1][2] <= -ik_fixed_pkg::fix_mul(ct, sa);
			dh_mat[1][3] <= ik_fixed_pkg::fix_mul(a_len, st);
			dh_mat[2][0] <= '0;
			dh_mat[2][1] <= sa;
			dh_mat[2][2] <= ca;
			dh_mat[2][3] <= d_off;
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 4; c++) begin
					if (joint == 3'd0) begin
						prev[r][c] <= (r == c) ? ik_fixed_pkg::FIX_ONE : '0;
					end else begin
						prev[r][c] <= pose.frames[joint - 3'd1][r][c];
					end
				end
			end
		end
		if (state == ik_fixed_pkg::MULT) begin
			pose.frames[joint][row][col] <= elem_sum;
		end
	end

	always_comb begin
		for (int k = 0; k < 3; k++) begin
			mat_col[k] = dh_mat[k][col];
		end
		mat_col[3] = (col == 2'd3) ? ik_fixed_pkg::FIX_ONE : '0; // implicit bottom row
	end

	// row of the previous frame times column of the DH matrix
	always_comb begin
		elem_sum = '0;
		for (int k = 0; k < 4; k++) begin
			elem_sum = elem_sum + ik_fixed_pkg::fix_mul(prev[row][k], mat_col[k]);
		end
	end

	assign prm.busy = state == ik_fixed_pkg::BUILD || state == ik_fixed_pkg::MULT;
	assign pose.done = state == ik_fixed_pkg::DONE;

	assign pose.end_x = pose.frames[MAX_JOINT-1][0][3];
	assign pose.end_y = pose.frames[MAX_JOINT-1][1][3];
	assign pose.end_z = pose.frames[MAX_JOINT-1][2][3];

endmodule

/* pose_readout.sv */
// host-side results: registered matrix element select, squared distance
// from the last frame origin to the target, and the ready level
`timescale 1ns/100ps

module pose_readout #(
	parameter int MAX_JOINT = 6
) (
	input logic clk,
	input logic reset,
	dh_param_if.readout prm,
	pose_if.readout pose,
	input logic busy_in,
	input logic [2:0] joint_select,
	input ik_fixed_pkg::row_t row_select,
	input ik_fixed_pkg::col_t col_select,
	output ik_fixed_pkg::fix_t data,
	output ik_fixed_pkg::fix_t dist_sq,
	output logic ready
);

	localparam int SUM_W = 2 * ik_fixed_pkg::WORD_W + 2; // three squares without overflow
	localparam ik_fixed_pkg::fix_t FIX_MAX = {1'b0, {(ik_fixed_pkg::WORD_W - 1){1'b1}}};

	ik_fixed_pkg::fix_t end_pos [3];
	ik_fixed_pkg::fix_t diff [3];
	logic [SUM_W-1:0] sq_sum;
	logic seen_done; // frames hold a finished result

	assign end_pos[0] = pose.end_x;
	assign end_pos[1] = pose.end_y;
	assign end_pos[2] = pose.end_z;

	always_comb begin
		sq_sum = '0;
		for (int k = 0; k < 3; k++) begin
			diff[k] = prm.target[k] - end_pos[k];
			sq_sum = sq_sum + SUM_W'(ik_fixed_pkg::fix_mul_full(diff[k], diff[k]));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			data <= '0;
			dist_sq <= '0;
			seen_done <= 1'b0;
		end else begin
			if (!seen_done || joint_select >= 3'(MAX_JOINT)) begin
				data <= '0;
			end else if (row_select == 2'd3) begin
				data <= (col_select == 2'd3) ? ik_fixed_pkg::FIX_ONE : '0;
			end else begin
				data <= pose.frames[joint_select][row_select][col_select];
			end
			if (pose.done) begin
				dist_sq <= (sq_sum > SUM_W'(FIX_MAX)) ? FIX_MAX : ik_fixed_pkg::fix_t'(sq_sum);
				seen_done <= 1'b1;
			end
		end
	end

	// held low in the done cycle while dist_sq loads
	assign ready = seen_done && !busy_in && !pose.done;

endmodule

/* ik_swift_top.sv */
// robot-arm forward kinematics front end
// host writes target and DH words byte by byte, then reads cumulative
// frames and the squared target distance once ready is high
`timescale 1ns/100ps

module ik_swift_top #(
	parameter int MAX_JOINT = 6
) (
	input logic clk,
	input logic reset,
	input logic chipselect,
	input logic write,
	input ik_regmap_pkg::addr_t address,
	input ik_regmap_pkg::byte_t writedata,
	input logic [2:0] joint_select,
	input ik_fixed_pkg::row_t row_select,
	input ik_fixed_pkg::col_t col_select,
	output ik_fixed_pkg::fix_t data,
	output ik_fixed_pkg::fix_t dist_sq,
	output logic ready
);

	dh_param_if #(.MAX_JOINT(MAX_JOINT)) prm_bus ();
	pose_if #(.MAX_JOINT(MAX_JOINT)) pose_bus ();

	ik_param_regs #(.MAX_JOINT(MAX_JOINT)) u_regs (
		.clk(clk),
		.reset(reset),
		.chipselect(chipselect),
		.write(write),
		.address(address),
		.writedata(writedata),
		.regs(prm_bus.regs)
	);

	dh_chain #(.MAX_JOINT(MAX_JOINT)) u_chain (
		.clk(clk),
		.reset(reset),
		.prm(prm_bus.chain),
		.pose(pose_bus.chain)
	);

	pose_readout #(.MAX_JOINT(MAX_JOINT)) u_readout (
		.clk(clk),
		.reset(reset),
		.prm(prm_bus.readout),
		.pose(pose_bus.readout),
		.busy_in(prm_bus.busy),
		.joint_select(joint_select),
		.row_select(row_select),
		.col_select(col_select),
		.data(data),
		.dist_sq(dist_sq),
		.ready(ready)
	);

endmodule

/* tb_ik_swift_chk.sv */
// protocol assertions on the chain's start, busy and done signals
// bound into every dh_chain instance
`timescale 1ns/100ps

module tb_ik_swift_chk #(
	parameter int MAX_JOINT = 6
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done
);

	localparam int RUN_CYCLES = 13 * MAX_JOINT + 1; // one BUILD and 12 MULT per joint, then DONE

	start_idle: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
		else $error("start strobe seen while the chain is busy");

	done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done held high for more than one cycle");

	busy_drop: assert property (@(posedge clk) disable iff (reset) done |-> !busy && $past(busy))
		else $error("busy did not fall together with done");

	run_length: assert property (@(posedge clk) disable iff (reset) start |-> ##RUN_CYCLES done)
		else $error("done did not follow start after %0d cycles", RUN_CYCLES);

endmodule

bind dh_chain tb_ik_swift_chk #(.MAX_JOINT(MAX_JOINT)) u_chk (
	.clk(clk),
	.reset(reset),
	.start(prm.start),
	.busy(prm.busy),
	.done(pose.done)
);

/* tb_ik_swift.sv */
// directed testbench for ik_swift_top with its own model of the DH chain
// each test writes words byte by byte, starts a run, waits for ready
// and compares every cumulative frame element and dist_sq
`timescale 1ns/100ps

module tb_ik_swift;

	typedef ik_fixed_pkg::fix_t fix_t;
	localparam int MAX_J = 6;
	localparam int RUN_CYCLES = 13 * MAX_J + 1;
	localparam int WATCHDOG_NS = 6 * (400 + 13 * MAX_J + 60) * 20;
	localparam fix_t ONE = 27'sd65536;
	localparam longint FIX_MAX = 64'd67108863; // largest positive word

`include "sine_table.svh"

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic chipselect = 1'b0;
	logic write = 1'b0;
	ik_regmap_pkg::addr_t address = '0;
	ik_regmap_pkg::byte_t writedata = '0;
	logic [2:0] joint_select = '0;
	ik_fixed_pkg::row_t row_select = '0;
	ik_fixed_pkg::col_t col_select = '0;
	fix_t data;
	fix_t dist_sq;
	logic ready;

	fix_t dh_val [MAX_J][4]; // theta, d, a, alpha as the DUT should hold them
	fix_t tgt_val [3];
	fix_t ref_frame [MAX_J][3][4];
	fix_t ref_dist;
	logic [15:0] lfsr = 16'd19867;
	int checks = 0;
	int errors = 0;
	int chk_mark = 0;
	int err_mark = 0;

	ik_swift_top #(.MAX_JOINT(MAX_J)) UUT (.*);

	always #10 clk = ~clk;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: tests still running after %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, sign extended from n bits
	function automatic fix_t lfsr_fix(int n);
		logic signed [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			lfsr = {lfsr[14:0], v[0]};
		end
		v = v <<< (32 - n);
		return fix_t'(v >>> (32 - n));
	endfunction

	function automatic fix_t ref_mul(fix_t a, fix_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return fix_t'(p >>> 16); // floor, then wrap to 27 bits
	endfunction

	function automatic fix_t ref_sin(logic [7:0] ang);
		int i;
		int mag;
		i = int'(ang[5:0]);
		mag = ang[6] ? int'(SINE_Q16[64 - i]) : int'(SINE_Q16[i]);
		return fix_t'(ang[7] ? -mag : mag);
	endfunction

	function automatic void build_model();
		fix_t a_mat [4][4];
		fix_t prev [4][4];
		fix_t st, ct, sa, ca, a_len, diff;
		longint sq;
		prev = '{default: '{default: fix_t'(0)}};
		for (int k = 0; k < 4; k++) begin
			prev[k][k] = ONE;
		end
		for (int j = 0; j < MAX_J; j++) begin
			st = ref_sin(dh_val[j][ik_regmap_pkg::THETA][7:0]);
			ct = ref_sin(8'(dh_val[j][ik_regmap_pkg::THETA][7:0] + 8'd64));
			sa = ref_sin(dh_val[j][ik_regmap_pkg::ALPHA][7:0]);
			ca = ref_sin(8'(dh_val[j][ik_regmap_pkg::ALPHA][7:0] + 8'd64));
			a_len = dh_val[j][ik_regmap_pkg::L_DISTANCE];
			a_mat[0] = '{ct, -ref_mul(st, ca), ref_mul(st, sa), ref_mul(a_len, ct)};
			a_mat[1] = '{st, ref_mul(ct, ca), -ref_mul(ct, sa), ref_mul(a_len, st)};
			a_mat[2] = '{fix_t'(0), sa, ca, dh_val[j][ik_regmap_pkg::L_OFFSET]};
			a_mat[3] = '{fix_t'(0), fix_t'(0), fix_t'(0), ONE};
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 4; c++) begin
					ref_frame[j][r][c] = '0;
					for (int k = 0; k < 4; k++) begin
						ref_frame[j][r][c] = ref_frame[j][r][c] + ref_mul(prev[r][k], a_mat[k][c]);
					end
				end
				prev[r] = ref_frame[j][r]; // row r of the next product needs only row r
			end
		end
		sq = 0;
		for (int k = 0; k < 3; k++) begin
			diff = tgt_val[k] - ref_frame[MAX_J-1][k][3];
			sq = sq + ((longint'(diff) * longint'(diff)) >>> 16);
		end
		ref_dist = (sq > FIX_MAX) ? fix_t'(FIX_MAX) : fix_t'(sq);
	endfunction

	task automatic check_value(string name, string what, fix_t exp, fix_t act);
		checks++;
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(string name);
		$display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	task automatic write_byte(int addr, ik_regmap_pkg::byte_t b);
		@(posedge clk);
		chipselect <= 1'b1;
		write <= 1'b1;
		address <= ik_regmap_pkg::addr_t'(addr);
		writedata <= b;
	endtask

	// top byte first, it carries only bits 26:24
	task automatic write_word(int addr, fix_t w);
		write_byte(addr, {5'b0, w[26:24]});
		write_byte(addr + 1, w[23:16]);
		write_byte(addr + 2, w[15:8]);
		write_byte(addr + 3, w[7:0]);
	endtask

	task automatic bus_idle();
		@(posedge clk);
		chipselect <= 1'b0;
		write <= 1'b0;
	endtask

	task automatic load_params();
		for (int j = 0; j < MAX_J; j++) begin
			for (int f = 0; f < 4; f++) begin
				write_word(ik_regmap_pkg::DH_BASE + 16 * j + 4 * f, dh_val[j][f]);
			end
		end
		for (int k = 0; k < 3; k++) begin
			write_word(ik_regmap_pkg::TARGET_BASE + 4 * k, tgt_val[k]);
		end
		bus_idle();
	endtask

	// ready drops once busy rises, two cycles after the start write
	task automatic start_run(string name);
		int n;
		write_byte(int'(ik_regmap_pkg::START_ADDR), 8'h00);
		bus_idle();
		n = 0;
		@(negedge clk);
		while (ready && n < 8) begin
			@(negedge clk);
			n++;
		end
		assert (!ready) else begin
			$display("%s: ready did not fall after the start write", name);
			errors++;
		end
	endtask

	task automatic wait_ready(string name);
		int n;
		n = 0;
		while (!ready && n < RUN_CYCLES + 20) begin
			@(negedge clk);
			n++;
		end
		assert (ready) else begin
			$display("%s: ready still low %0d cycles after start", name, n);
			errors++;
		end
	endtask

	task automatic read_elem(int j, int r, int c, output fix_t v);
		@(posedge clk);
		joint_select <= 3'(j);
		row_select <= 2'(r);
		col_select <= 2'(c);
		@(posedge clk); // data registers the select here
		@(negedge clk);
		v = data;
	endtask

	task automatic check_zero(string name, int j_lo, int j_hi);
		fix_t got;
		for (int j = j_lo; j <= j_hi; j++) begin
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					read_elem(j, r, c, got);
					check_value(name, $sformatf("T%0d[%0d][%0d]", j, r, c), fix_t'(0), got);
				end
			end
		end
	endtask

	task automatic check_frames(string name);
		fix_t got;
		fix_t exp;
		build_model();
		for (int j = 0; j < MAX_J; j++) begin
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					read_elem(j, r, c, got);
					if (r < 3) begin
						exp = ref_frame[j][r][c];
					end else begin
						exp = (c == 3) ? ONE : fix_t'(0); // fixed bottom row
					end
					check_value(name, $sformatf("T%0d[%0d][%0d]", j, r, c), exp, got);
				end
			end
		end
		check_value(name, "dist_sq", ref_dist, dist_sq);
	endtask

	task automatic run_and_check(string name);
		load_params();
		start_run(name);
		wait_ready(name);
		check_frames(name);
		end_test(name);
	endtask

	initial begin
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		check_value("reset_state", "ready", fix_t'(0), fix_t'(ready));
		check_value("reset_state", "dist_sq", fix_t'(0), dist_sq);
		check_zero("reset_state", 0, 7);
		end_test("reset_state");

		dh_val = '{default: '{default: fix_t'(0)}};
		tgt_val = '{default: fix_t'(0)};
		run_and_check("identity_chain");

		for (int j = 0; j < MAX_J; j++) begin
			dh_val[j] = '{fix_t'(64), fix_t'(0), ONE, fix_t'(0)}; // quarter turn, a = 1.0
		end
		tgt_val = '{ONE, ONE, ONE};
		run_and_check("quarter_turn");

		for (int j = 0; j < MAX_J; j++) begin
			for (int f = 0; f < 4; f++) begin
				dh_val[j][f] = lfsr_fix((f == 0 || f == 3) ? 27 : 19); // lengths within 4.0
			end
		end
		for (int k = 0; k < 3; k++) begin
			tgt_val[k] = lfsr_fix(20);
		end
		run_and_check("random_arm");

		// same parameters again, these writes land while busy and are dropped
		// the last joint is built late in the run, so a stored write would show
		start_run("busy_writes");
		for (int f = 0; f < 4; f++) begin
			write_word(ik_regmap_pkg::DH_BASE + 16 * (MAX_J - 1) + 4 * f, fix_t'(27'h155aa55));
		end
		write_word(ik_regmap_pkg::TARGET_BASE, ONE);
		bus_idle();
		@(negedge clk);
		check_value("busy_writes", "ready while busy", fix_t'(0), fix_t'(ready));
		wait_ready("busy_writes");
		check_frames("busy_writes");
		end_test("busy_writes");

		check_zero("out_of_range", MAX_J, 7);
		tgt_val = '{default: fix_t'(27'sd65536000)}; // 1000.0 on every axis
		for (int k = 0; k < 3; k++) begin
			write_word(ik_regmap_pkg::TARGET_BASE + 4 * k, tgt_val[k]);
		end
		bus_idle();
		start_run("out_of_range");
		wait_ready("out_of_range");
		check_value("out_of_range", "dist_sq", fix_t'(FIX_MAX), dist_sq);
		end_test("out_of_range");

		$display("all tests: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+.
ik_fixed_pkg.sv
ik_regmap_pkg.sv
ik_ifs.sv
ik_param_regs.sv
dh_chain.sv
pose_readout.sv
ik_swift_top.sv
tb_ik_swift_chk.sv
tb_ik_swift.sv

/* run.sh */
#!/bin/sh
# compile the testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ik_swift -f list.f > sim.log 2>&1 &&
	./obj_dir/Vtb_ik_swift >> sim.log 2>&1 ||
	echo "build or simulator error, TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
exit 0
